// File: isaPkg.sv
package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Opcode in bits 7 to 3 and flags in bits 2 to 0
	////////////////////////////////////////////////////////////////////////////

	localparam int OpWidth = 5;
	localparam int FlagWidth = 3;
	localparam int DataWidth = 8;   // Data, operand and instruction bytes

	// Anything outside the kept opcodes runs as a NOP
	typedef enum logic [OpWidth-1:0] {
		OpAdd  = 5'b00000,
		OpSub  = 5'b00001,
		OpOr   = 5'b00011,
		OpAnd  = 5'b00100,
		OpShft = 5'b00101,
		OpLoad = 5'b01010,
		OpStor = 5'b01011,
		OpNop  = 5'b01111
	} opcodeT;

	// Addressing flags plus the one shift code with no addressing twin
	typedef enum logic [FlagWidth-1:0] {
		FlDirect    = 3'b000,
		FlIndirect  = 3'b001,
		FlImmediate = 3'b010,
		FlShrOne    = 3'b011
	} flagT;

	// Shift flags reuse the addressing codes
	localparam flagT FlShlZero = FlDirect;
	localparam flagT FlShlOne = FlIndirect;
	localparam flagT FlShrZero = FlImmediate;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

	// What the sequencer has to do with a decoded instruction
	typedef enum logic [2:0] {Alu, Load, Store, Shift, Nop} opClassT;

	typedef enum logic [1:0] {Direct, Indirect, Immediate} modeT;

	typedef enum logic [3:0] {
		Add,
		Sub,
		Or,
		And,
		Pass,       // LOAD
		ShlZero,
		ShlOne,
		ShrZero,
		ShrOne
	} aluOpT;

	typedef enum logic [2:0] {
		Idle, Dispatch, PtrRead, OperandRead, Execute, StoreWrite
	} seqStateT;

endpackage

// File: instrDecode.sv
`timescale 1ns/1ps

module instrDecode import isaPkg::*, ctrlPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 instrLoad,
	input  logic [DataWidth-1:0] instr,
	input  logic [DataWidth-1:0] operand,
	output opClassT              opClass,
	output modeT                 mode,
	output aluOpT                aluOp,
	output logic [DataWidth-1:0] operandReg
);

	logic [DataWidth-1:0] instrReg;
	opcodeT opcode;
	flagT flag;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrReg <= {OpNop, FlDirect};   // Idle decodes as NOP
		end else if (instrLoad) begin
			instrReg <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (instrLoad) begin
			operandReg <= operand;
		end
	end

	assign opcode = opcodeT'(instrReg[DataWidth-1 -: OpWidth]);
	assign flag = flagT'(instrReg[FlagWidth-1:0]);

	always_comb begin
		case (flag)
			FlIndirect:  mode = Indirect;
			FlImmediate: mode = Immediate;
			default:     mode = Direct;
		endcase
	end

	always_comb begin
		opClass = Nop;
		aluOp = Pass;
		case (opcode)
			OpAdd, OpSub, OpOr, OpAnd: begin
				if (flag == FlDirect || flag == FlIndirect || flag == FlImmediate) begin
					opClass = Alu;
				end
				case (opcode)
					OpAdd:   aluOp = Add;
					OpSub:   aluOp = Sub;
					OpOr:    aluOp = Or;
					default: aluOp = And;
				endcase
			end
			OpLoad: begin
				if (flag == FlDirect || flag == FlIndirect || flag == FlImmediate) begin
					opClass = Load;
				end
			end
			OpStor: begin
				if (flag == FlDirect || flag == FlIndirect) begin   // No immediate store
					opClass = Store;
				end
			end
			OpShft: begin
				opClass = Shift;
				case (flag)
					FlShlZero: aluOp = ShlZero;
					FlShlOne:  aluOp = ShlOne;
					FlShrZero: aluOp = ShrZero;
					FlShrOne:  aluOp = ShrOne;
					default:   opClass = Nop;
				endcase
			end
			default: opClass = Nop;   // Dropped opcodes
		endcase
	end

	// The case default would turn an unknown instruction into a quiet NOP
	assert property (@(posedge clk) disable iff (!rstN) !$isunknown(instrReg));

endmodule

// File: controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import isaPkg::*, ctrlPkg::*; #(
	parameter int AddrWidth = 4
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 instrValid,
	input  opClassT              opClass,
	input  modeT                 mode,
	input  logic [DataWidth-1:0] operandReg,
	input  logic [DataWidth-1:0] memRdata,
	output logic                 ready,
	output logic                 instrLoad,
	output logic                 memWrite,
	output logic                 immSel,
	output logic                 accWrite,
	output logic [AddrWidth-1:0] memAddr
);

	seqStateT state;
	seqStateT nextState;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (instrValid) begin
					nextState = Dispatch;
				end
			end
			Dispatch: begin
				case (opClass)
					Alu, Load: begin
						case (mode)
							Indirect:  nextState = PtrRead;
							Immediate: nextState = Execute;
							default:   nextState = OperandRead;
						endcase
					end
					Store:   nextState = (mode == Indirect) ? PtrRead : StoreWrite;
					Shift:   nextState = Execute;
					default: nextState = Idle;
				endcase
			end
			PtrRead:     nextState = (opClass == Store) ? StoreWrite : OperandRead;
			OperandRead: nextState = Execute;   // Read data lands next cycle
			Execute:     nextState = Idle;
			StoreWrite:  nextState = Idle;
			default:     nextState = Idle;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobes
	////////////////////////////////////////////////////////////////////////////

	assign ready = (state == Idle);
	assign instrLoad = ready && instrValid;
	assign memWrite = (state == StoreWrite);
	assign accWrite = (state == Execute);
	assign immSel = (mode == Immediate);

	// Pointer fetched in PtrRead sits on memRdata for the following phase
	always_comb begin
		if (mode == Indirect && (state == OperandRead || state == StoreWrite)) begin
			memAddr = memRdata[AddrWidth-1:0];
		end else begin
			memAddr = operandReg[AddrWidth-1:0];
		end
	end

	// Only a store may reach the memory write phase
	assert property (@(posedge clk) disable iff (!rstN) memWrite |-> (opClass == Store));
	assert property (@(posedge clk) disable iff (!rstN) instrLoad |=> !ready);

endmodule

// File: aluShifter.sv
`timescale 1ns/1ps

module aluShifter import isaPkg::*, ctrlPkg::*; (
	input  logic [DataWidth-1:0] acc,
	input  logic [DataWidth-1:0] operandReg,
	input  logic [DataWidth-1:0] memRdata,
	input  logic                 immSel,
	input  aluOpT                aluOp,
	output logic [DataWidth-1:0] aluResult
);

	logic [DataWidth-1:0] opB;
	logic [2:0] shAmt;
	logic [DataWidth-1:0] lowFill;
	logic [DataWidth-1:0] highFill;

	assign opB = immSel ? operandReg : memRdata;
	assign shAmt = operandReg[2:0];

	// Masks of the bit positions a shift vacates
	assign lowFill = ~({DataWidth{1'b1}} << shAmt);
	assign highFill = ~({DataWidth{1'b1}} >> shAmt);

	always_comb begin
		case (aluOp)
			Add:     aluResult = acc + opB;   // Wraps mod 256
			Sub:     aluResult = acc - opB;
			Or:      aluResult = acc | opB;
			And:     aluResult = acc & opB;
			ShlZero: aluResult = acc << shAmt;
			ShlOne:  aluResult = (acc << shAmt) | lowFill;
			ShrZero: aluResult = acc >> shAmt;
			ShrOne:  aluResult = (acc >> shAmt) | highFill;
			default: aluResult = opB;   // Pass
		endcase
	end

endmodule

// File: accWriteback.sv
`timescale 1ns/1ps

module accWriteback import isaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 accWrite,
	input  logic [DataWidth-1:0] aluResult,
	output logic [DataWidth-1:0] acc
);

	////////////////////////////////////////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acc <= '0;
		end else if (accWrite) begin
			acc <= aluResult;   // Single write per instruction
		end
	end

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory import isaPkg::*; #(
	parameter int AddrWidth = 4
) (
	input  logic                 clk,
	input  logic                 memWrite,
	input  logic [AddrWidth-1:0] memAddr,
	input  logic [DataWidth-1:0] wdata,
	output logic [DataWidth-1:0] memRdata
);

	logic [DataWidth-1:0] mem [2**AddrWidth];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr] <= wdata;
		end
		memRdata <= mem[memAddr];   // Old data on a same-address write
	end

	assert property (@(posedge clk) memWrite |-> !$isunknown(memAddr));

endmodule

// File: accumulatorCore.sv
`timescale 1ns/1ps

module accumulatorCore import isaPkg::*, ctrlPkg::*; #(
	parameter int AddrWidth = 4
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [DataWidth-1:0] instr,
	input  logic [DataWidth-1:0] operand,
	input  logic                 instrValid,
	output logic                 ready,
	output logic [DataWidth-1:0] acc
);

	opClassT opClass;
	modeT mode;
	aluOpT aluOp;
	logic [DataWidth-1:0] operandReg;
	logic [DataWidth-1:0] memRdata;
	logic [DataWidth-1:0] aluResult;
	logic [AddrWidth-1:0] memAddr;
	logic instrLoad;
	logic memWrite;
	logic immSel;
	logic accWrite;

	instrDecode decode (
		.clk, .rstN, .instrLoad, .instr, .operand,
		.opClass, .mode, .aluOp, .operandReg
	);

	controlSequencer #(.AddrWidth(AddrWidth)) sequencer (
		.clk, .rstN, .instrValid, .opClass, .mode, .operandReg, .memRdata,
		.ready, .instrLoad, .memWrite, .immSel, .accWrite, .memAddr
	);

	aluShifter alu (
		.acc, .operandReg, .memRdata, .immSel, .aluOp, .aluResult
	);

	accWriteback writeback (
		.clk, .rstN, .accWrite, .aluResult, .acc
	);

	// Stores always write the accumulator
	dataMemory #(.AddrWidth(AddrWidth)) dmem (
		.clk, .memWrite, .memAddr, .wdata(acc), .memRdata
	);

endmodule

// File: tbAccumulatorCore.sv
`timescale 1ns/1ps

module tbAccumulatorCore import isaPkg::*; ();

	localparam int AddrWidth = 4;
	localparam int Words = 2 ** AddrWidth;
	localparam int ClkPeriod = 100;
	localparam int NumImm = 40;
	localparam int NumDir = 30;
	localparam int NumInd = 8;   // Six instructions per pass
	localparam int NumShift = 24;   // Load plus shift per pass
	localparam int NumInstr = NumImm + 2 * Words + NumDir + 6 * NumInd + 2 * NumShift + 6;

	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	logic ready;
	logic [DataWidth-1:0] instr, operand, acc;

	logic [DataWidth-1:0] modelMem [Words];
	logic [DataWidth-1:0] expAcc = '0;
	logic readyPrev = 1'b1;
	string testName = "reset";
	integer seed = 32'h88019498;
	int errors = 0;
	int checks = 0;
	int issued = 0;

	accumulatorCore #(.AddrWidth(AddrWidth)) uut (
		.clk, .rstN, .instr, .operand, .instrValid, .ready, .acc
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic int unsigned pick(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [DataWidth-1:0] randByte();
		return DataWidth'(pick(256));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Bit by bit, vacated positions take the fill bit
	function automatic logic [DataWidth-1:0] shiftRef(input logic [DataWidth-1:0] value,
			input int amt, input bit left, input logic fill);
		logic [DataWidth-1:0] res;
		for (int i = 0; i < DataWidth; i++) begin
			if (left) begin
				res[i] = (i >= amt) ? value[i - amt] : fill;
			end else begin
				res[i] = (i + amt < DataWidth) ? value[i + amt] : fill;
			end
		end
		return res;
	endfunction

	function automatic logic [DataWidth-1:0] refAcc(input logic [DataWidth-1:0] ins,
			input logic [DataWidth-1:0] opnd, input logic [DataWidth-1:0] accNow);
		logic [OpWidth-1:0] op;
		logic [FlagWidth-1:0] fl;
		logic [DataWidth-1:0] word;
		logic [DataWidth-1:0] src;
		op = ins[DataWidth-1 -: OpWidth];
		fl = ins[FlagWidth-1:0];
		word = modelMem[opnd[AddrWidth-1:0]];
		case (fl)
			FlDirect:   src = word;
			FlIndirect: src = modelMem[word[AddrWidth-1:0]];   // Word is the pointer
			default:    src = opnd;
		endcase
		if (op == OpShft) begin
			case (fl)
				FlShlZero: return shiftRef(accNow, int'(opnd[2:0]), 1'b1, 1'b0);
				FlShlOne:  return shiftRef(accNow, int'(opnd[2:0]), 1'b1, 1'b1);
				FlShrZero: return shiftRef(accNow, int'(opnd[2:0]), 1'b0, 1'b0);
				FlShrOne:  return shiftRef(accNow, int'(opnd[2:0]), 1'b0, 1'b1);
				default:   return accNow;
			endcase
		end
		if (fl > FlImmediate) begin
			return accNow;   // No addressing mode
		end
		case (op)
			OpLoad:  return src;
			OpAdd:   return accNow + src;
			OpSub:   return accNow - src;
			OpOr:    return accNow | src;
			OpAnd:   return accNow & src;
			default: return accNow;   // NOP, STOR, dropped opcodes
		endcase
	endfunction

	task automatic runInstr(input logic [OpWidth-1:0] op, input logic [FlagWidth-1:0] fl,
			input logic [DataWidth-1:0] opnd, input string name, input bit stray = 1'b0);
		logic [DataWidth-1:0] word;
		word = modelMem[opnd[AddrWidth-1:0]];
		@(posedge clk);
		instr <= {op, fl};
		operand <= opnd;
		instrValid <= 1'b1;
		expAcc = refAcc({op, fl}, opnd, expAcc);
		if (op == OpStor && fl == FlDirect) begin
			modelMem[opnd[AddrWidth-1:0]] = expAcc;
		end else if (op == OpStor && fl == FlIndirect) begin
			modelMem[word[AddrWidth-1:0]] = expAcc;
		end
		testName = name;
		issued++;
		@(posedge clk);
		instrValid <= 1'b0;
		if (stray) begin
			@(posedge clk);
			instr <= {OpAdd, FlImmediate};   // Arrives while busy
			instrValid <= 1'b1;
			@(posedge clk);
			instrValid <= 1'b0;
		end
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
	endtask

	// Compare on every rising ready
	always @(negedge clk) begin
		if (rstN === 1'b1 && ready === 1'b1 && readyPrev === 1'b0) begin
			checks++;
			assert (acc === expAcc) else begin
				$display("FAIL %s: expected %02h, actual %02h", testName, expAcc, acc);
				errors++;
			end
		end
		readyPrev = ready;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		opcodeT aluOps[5];
		opcodeT op;
		logic [DataWidth-1:0] ptrAddr;
		aluOps = '{OpLoad, OpAdd, OpSub, OpOr, OpAnd};
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		operand = '0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		assert (ready === 1'b1 && acc === '0) else begin
			$display("After reset the core is not ready or acc is not zero");
			errors++;
		end
		runInstr(OpLoad, FlImmediate, randByte(), "imm LOAD");
		for (int i = 1; i < NumImm; i++) begin
			op = aluOps[pick(5)];
			runInstr(op, FlImmediate, randByte(), $sformatf("imm %s", op.name()));
		end
		for (int a = 0; a < Words; a++) begin   // Fill memory before any read
			runInstr(OpLoad, FlImmediate, randByte(), "dir setup");
			runInstr(OpStor, FlDirect, DataWidth'(a), "dir STOR");
		end
		for (int i = 0; i < NumDir; i++) begin
			op = aluOps[pick(5)];
			runInstr(op, FlDirect, randByte(), $sformatf("dir %s", op.name()));
		end
		for (int i = 0; i < NumInd; i++) begin
			ptrAddr = randByte();
			runInstr(OpLoad, FlImmediate, randByte(), "ind pointer setup");
			runInstr(OpStor, FlDirect, ptrAddr, "ind pointer STOR");
			runInstr(OpLoad, FlImmediate, randByte(), "ind data setup");
			runInstr(OpStor, FlIndirect, ptrAddr, "ind STOR");
			runInstr(OpLoad, FlIndirect, ptrAddr, "ind LOAD");
			op = aluOps[pick(5)];
			runInstr(op, FlIndirect, randByte(), $sformatf("ind %s", op.name()));
		end
		for (int i = 0; i < NumShift; i++) begin
			runInstr(OpLoad, FlImmediate, randByte(), "shift setup");
			runInstr(OpShft, FlagWidth'(i % 4), randByte(), $sformatf("SHFT flag %0d", i % 4));
		end
		runInstr(OpLoad, FlImmediate, 8'h5a, "misc setup");
		runInstr(OpNop, FlDirect, randByte(), "NOP");
		runInstr(5'b00010, FlDirect, 8'h03, "dropped opcode");   // Unused code
		runInstr(OpStor, FlImmediate, 8'h07, "STOR immediate");
		runInstr(OpLoad, FlDirect, 8'h07, "LOAD after STOR immediate");
		runInstr(OpLoad, FlIndirect, randByte(), "strobe while busy", 1'b1);
		repeat (2) @(negedge clk);
		assert (checks == issued) else begin
			$display("Ready rose %0d times for %0d instructions", checks, issued);
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(ClkPeriod * (NumInstr * 8 + 20));
		$display("Timeout: the core never returned ready within the expected run time");
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: project.f
isaPkg.sv
ctrlPkg.sv
instrDecode.sv
controlSequencer.sv
aluShifter.sv
accWriteback.sv
dataMemory.sv
accumulatorCore.sv
tbAccumulatorCore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbAccumulatorCore \
	-f project.f -o simAccumulatorCore
./obj_dir/simAccumulatorCore | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
